/* verilog/sender_pkg.sv */
package sender_pkg;

    ////////////////////////////////////////
    // Frame constants
    ////////////////////////////////////////
    localparam logic [7:0] ESC_BYTE   = 8'h10;
    localparam logic [7:0] START_CHAR = 8'h21;
    localparam logic [7:0] CR_CHAR    = 8'h0D;
    localparam logic [7:0] LF_CHAR    = 8'h0A;

    localparam int MSG_BYTES    = 15;
    localparam int MSG_LEN_W    = 4;
    localparam int STATUS_BYTES = 5;
    // "!" and length character ahead of the payload
    localparam int FRAME_BYTES  = 2 + MSG_BYTES;
    // Header, every payload byte doubled, then CR LF
    localparam int WORST_FRAME_BYTES = 2 + 2 * MSG_BYTES + 2;

    ////////////////////////////////////////
    // Enums
    ////////////////////////////////////////
    typedef enum logic [7:0] {
        CMD_C = 8'h43,
        CMD_R = 8'h52,
        CMD_W = 8'h57
    } esc_cmd_e;

    typedef enum logic [3:0] {
        INIT,
        INIT_WAIT,
        IDLE,
        FLUSH_WAIT,
        ESC_BYTE_SEND,
        ESC_CHAR_SEND,
        FRAME_SEND,
        TERM_CR,
        TERM_LF
    } sender_state_e;

    ////////////////////////////////////////
    // Port structs
    ////////////////////////////////////////
    typedef struct packed {
        logic [MSG_LEN_W-1:0]   length;
        // First byte sits in the top bits
        logic [MSG_BYTES*8-1:0] payload;
    } msg_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] char;
    } cmd_t;

    typedef struct packed {
        logic [31:0] word;
        logic        capture_implemented;
        logic        armed;
        logic        triggered;
    } status_t;

endpackage

/* verilog/frame_sender_ctrl.sv */
`timescale 1ns/1ns

module frame_sender_ctrl #(
    parameter int RESET_WAIT = 15
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             msg_ready,
    input  sender_pkg::cmd_t cmd,
    input  byte              cur_byte,
    input  logic             remaining_zero,
    input  logic             fifo_full,
    output logic             load,
    output logic             kind,
    output logic             advance,
    output logic             flush,
    output logic             wr_en,
    output logic [7:0]       wr_data,
    output logic             ready
);
    import sender_pkg::*;

    localparam int WAIT_W = (RESET_WAIT > 0) ? $clog2(RESET_WAIT + 1) : 1;

    sender_state_e     state;
    esc_cmd_e          cmd_char;
    logic [WAIT_W-1:0] wait_cnt;
    logic              msg_ready_q;
    logic              msg_edge;
    logic              cmd_go;

    assign msg_edge = msg_ready && !msg_ready_q;

    // Commands win over everything once the FIFO has settled after reset
    assign cmd_go = cmd.valid && (cmd.char inside {CMD_C, CMD_R, CMD_W}) &&
                    (state != INIT) && (state != INIT_WAIT);

    assign ready = (state == IDLE) && !fifo_full;

    ////////////////////////////////////////
    // State register
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= INIT;
            cmd_char    <= CMD_C;
            wait_cnt    <= '0;
            msg_ready_q <= 1'b0;
            flush       <= 1'b0;
        end else begin
            msg_ready_q <= msg_ready;
            flush       <= 1'b0;
            if (cmd_go) begin
                state    <= FLUSH_WAIT;
                cmd_char <= esc_cmd_e'(cmd.char);
                wait_cnt <= WAIT_W'(RESET_WAIT);
                flush    <= 1'b1;
            end else begin
                case (state)
                    INIT: begin
                        state    <= INIT_WAIT;
                        wait_cnt <= WAIT_W'(RESET_WAIT);
                        flush    <= 1'b1;
                    end
                    INIT_WAIT, FLUSH_WAIT: begin
                        if (wait_cnt == '0) begin
                            state <= (state == INIT_WAIT) ? IDLE : ESC_BYTE_SEND;
                        end else begin
                            wait_cnt <= wait_cnt - 1'b1;
                        end
                    end
                    IDLE: begin
                        if (msg_edge) begin
                            state <= FRAME_SEND;
                        end
                    end
                    ESC_BYTE_SEND: state <= ESC_CHAR_SEND;
                    // Only R carries a status record
                    ESC_CHAR_SEND: state <= (cmd_char == CMD_R) ? FRAME_SEND : IDLE;
                    FRAME_SEND: begin
                        if (remaining_zero) begin
                            state <= TERM_CR;
                        end
                    end
                    TERM_CR: state <= TERM_LF;
                    TERM_LF: state <= IDLE;
                    default: state <= INIT;
                endcase
            end
        end
    end

    ////////////////////////////////////////
    // FIFO write and shifter strobes
    ////////////////////////////////////////
    always_comb begin
        load    = 1'b0;
        kind    = 1'b0;
        advance = 1'b0;
        wr_en   = 1'b0;
        wr_data = 8'h00;
        if (!cmd_go) begin
            case (state)
                IDLE: begin
                    load = msg_edge;
                end
                ESC_BYTE_SEND: begin
                    wr_en   = 1'b1;
                    wr_data = ESC_BYTE;
                end
                ESC_CHAR_SEND: begin
                    wr_en   = 1'b1;
                    wr_data = cmd_char;
                    load    = (cmd_char == CMD_R);
                    kind    = 1'b1;
                end
                FRAME_SEND: begin
                    wr_en   = 1'b1;
                    wr_data = cur_byte;
                    advance = 1'b1;
                end
                TERM_CR: begin
                    wr_en   = 1'b1;
                    wr_data = CR_CHAR;
                end
                TERM_LF: begin
                    wr_en   = 1'b1;
                    wr_data = LF_CHAR;
                end
                default: ;
            endcase
        end
    end

    a_state_legal: assert property (@(posedge clk) disable iff (rst)
        state inside {INIT, INIT_WAIT, IDLE, FLUSH_WAIT, ESC_BYTE_SEND,
                      ESC_CHAR_SEND, FRAME_SEND, TERM_CR, TERM_LF})
        else $error("frame_sender_ctrl: state outside the enum");

    // A flush one cycle late must not throw away a fresh write
    a_flush_no_write: assert property (@(posedge clk) disable iff (rst)
        !(flush && wr_en))
        else $error("frame_sender_ctrl: flush together with a FIFO write");

endmodule

/* verilog/frame_shifter.sv */
`timescale 1ns/1ns

module frame_shifter (
    input  logic                clk,
    input  logic                rst,
    input  logic                load,
    input  logic                kind,
    input  logic                advance,
    input  sender_pkg::msg_t    msg,
    input  sender_pkg::status_t status,
    output byte                 cur_byte,
    output logic                remaining_zero
);
    import sender_pkg::*;

    localparam int REM_W    = $clog2(FRAME_BYTES + 1);
    localparam int PAD_BITS = (FRAME_BYTES - STATUS_BYTES) * 8;

    logic [FRAME_BYTES*8-1:0] shreg;
    // Bytes still queued behind cur_byte
    logic [REM_W-1:0]         remaining;
    logic                     esc_seen;
    logic                     hold;

    function automatic logic [7:0] hex_ascii(input logic [MSG_LEN_W-1:0] nib);
        if (nib < 10) begin
            return 8'h30 + 8'(nib);
        end
        return 8'h37 + 8'(nib);
    endfunction

    assign cur_byte = shreg[FRAME_BYTES*8-1 -: 8];

    // First sight of an escape byte repeats it once
    assign hold           = (cur_byte == ESC_BYTE) && !esc_seen;
    assign remaining_zero = (remaining == '0) && !hold;

    always_ff @(posedge clk) begin
        if (load) begin
            if (kind) begin
                shreg <= {status.word, 5'b00000, status.capture_implemented,
                          status.armed, status.triggered, {PAD_BITS{1'b0}}};
            end else begin
                shreg <= {START_CHAR, hex_ascii(msg.length), msg.payload};
            end
        end else if (advance && !hold) begin
            shreg <= {shreg[FRAME_BYTES*8-9:0], 8'h00};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            remaining <= '0;
            esc_seen  <= 1'b0;
        end else if (load) begin
            // Count excludes the byte already on cur_byte
            remaining <= kind ? REM_W'(STATUS_BYTES - 1) : REM_W'(msg.length) + 1'b1;
            esc_seen  <= 1'b0;
        end else if (advance) begin
            if (hold) begin
                esc_seen <= 1'b1;
            end else begin
                esc_seen <= 1'b0;
                if (remaining != '0) begin
                    remaining <= remaining - 1'b1;
                end
            end
        end
    end

endmodule

/* verilog/byte_fifo.sv */
`timescale 1ns/1ns

module byte_fifo #(
    parameter int FIFO_DEPTH = 64
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       flush,
    input  logic       wr_en,
    input  logic [7:0] wr_data,
    input  logic       rd_en,
    output logic [7:0] rd_data,
    output logic       empty,
    output logic       full
);
    import sender_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [7:0]       mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    // Show-ahead read port
    assign rd_data = mem[rd_ptr];
    assign empty   = (count == '0);
    assign full    = (count == CNT_W'(FIFO_DEPTH));

    // Writes never stall, so one whole frame has to fit
    if (FIFO_DEPTH < WORST_FRAME_BYTES) begin : g_depth_check
        $error("byte_fifo: FIFO_DEPTH below the worst-case frame");
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst) wr_en |-> !full)
        else $error("byte_fifo: write while full");
    a_no_underflow: assert property (@(posedge clk) disable iff (rst) rd_en |-> !empty)
        else $error("byte_fifo: read while empty");

endmodule

/* verilog/baud_timer.sv */
`timescale 1ns/1ns

module baud_timer #(
    parameter int CLK_FREQ  = 100_000_000,
    parameter int BAUD_RATE = 57_600
) (
    input  logic clk,
    input  logic rst,
    input  logic restart,
    output logic tick
);
    localparam int BIT_CYCLES = CLK_FREQ / BAUD_RATE;
    localparam int CNT_W      = (BIT_CYCLES > 1) ? $clog2(BIT_CYCLES) : 1;

    logic [CNT_W-1:0] count;

    // Reload on restart so the start bit gets a full period
    always_ff @(posedge clk) begin
        if (rst || restart || (count == '0)) begin
            count <= CNT_W'(BIT_CYCLES - 1);
        end else begin
            count <= count - 1'b1;
        end
    end

    assign tick = (count == '0);

endmodule

/* verilog/uart_tx.sv */
`timescale 1ns/1ns

module uart_tx (
    input  logic clk,
    input  logic rst,
    input  byte  rd_data,
    input  logic empty,
    input  logic tick,
    output logic rd_en,
    output logic restart,
    output logic txd
);
    ////////////////////////////////////////
    // Line format
    ////////////////////////////////////////
    // Start bit, 8 data bits LSB first, two stop bits
    localparam int FRAME_BITS = 11;

    logic [FRAME_BITS-1:0] shreg;
    logic [3:0]            bits_left;
    logic                  idle;

    assign idle = (bits_left == 4'd0);

    // Pop as soon as the line is free
    assign rd_en   = idle && !empty;
    assign restart = rd_en;

    // Bit zero of the shift register drives the line
    assign txd = shreg[0];

    ////////////////////////////////////////
    // Shifter
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            shreg     <= '1;
            bits_left <= 4'd0;
        end else if (rd_en) begin
            shreg     <= {2'b11, rd_data, 1'b0};
            bits_left <= 4'(FRAME_BITS);
        end else if (tick && !idle) begin
            // Ones shift in behind the stop bits, so the line idles high
            shreg     <= {1'b1, shreg[FRAME_BITS-1:1]};
            bits_left <= bits_left - 1'b1;
        end
    end

    a_idle_high: assert property (@(posedge clk) disable iff (rst) idle |-> txd)
        else $error("uart_tx: line low while idle");

endmodule

/* verilog/data_sender.sv */
`timescale 1ns/1ns

module data_sender #(
    parameter int CLK_FREQ   = 100_000_000,
    parameter int BAUD_RATE  = 57_600,
    parameter int FIFO_DEPTH = 64,
    parameter int RESET_WAIT = 15
) (
    input  logic                clk,
    input  logic                rst,
    input  sender_pkg::msg_t    msg,
    input  logic                msg_ready,
    input  sender_pkg::cmd_t    cmd,
    input  sender_pkg::status_t status,
    output logic                txd,
    output logic                ready
);
    // Controller to shifter
    logic       load;
    logic       kind;
    logic       advance;
    byte        cur_byte;
    logic       remaining_zero;

    // Controller to FIFO
    logic       flush;
    logic       wr_en;
    logic [7:0] wr_data;
    logic       fifo_full;

    // FIFO to UART
    logic [7:0] rd_data;
    logic       fifo_empty;
    logic       rd_en;
    logic       restart;
    logic       tick;

    frame_sender_ctrl #(
        .RESET_WAIT(RESET_WAIT)
    ) u_ctrl (
        .clk(clk), .rst(rst), .msg_ready(msg_ready), .cmd(cmd),
        .cur_byte(cur_byte), .remaining_zero(remaining_zero), .fifo_full(fifo_full),
        .load(load), .kind(kind), .advance(advance), .flush(flush),
        .wr_en(wr_en), .wr_data(wr_data), .ready(ready)
    );

    frame_shifter u_shifter (
        .clk(clk), .rst(rst), .load(load), .kind(kind), .advance(advance),
        .msg(msg), .status(status), .cur_byte(cur_byte), .remaining_zero(remaining_zero)
    );

    byte_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .clk(clk), .rst(rst), .flush(flush), .wr_en(wr_en), .wr_data(wr_data),
        .rd_en(rd_en), .rd_data(rd_data), .empty(fifo_empty), .full(fifo_full)
    );

    baud_timer #(
        .CLK_FREQ(CLK_FREQ),
        .BAUD_RATE(BAUD_RATE)
    ) u_baud_timer (
        .clk(clk), .rst(rst), .restart(restart), .tick(tick)
    );

    uart_tx u_uart_tx (
        .clk(clk), .rst(rst), .rd_data(rd_data), .empty(fifo_empty), .tick(tick),
        .rd_en(rd_en), .restart(restart), .txd(txd)
    );

endmodule

/* tb/uart_decoder.sv */
`timescale 1ns/1ns

module uart_decoder #(
    parameter int BIT_CYCLES = 10
) (
    input  logic       clk,
    input  logic       txd,
    output logic [7:0] rx_byte,
    output logic       rx_valid,
    output logic       frame_err
);
    logic [7:0] data;

    // Line is sampled on the falling edge half a cycle away from the DUT edge
    initial begin
        rx_byte   = 8'h00;
        rx_valid  = 1'b0;
        frame_err = 1'b0;
        forever begin
            @(negedge clk);
            rx_valid  = 1'b0;
            frame_err = 1'b0;
            if (txd === 1'b0) begin
                // Middle of the start bit
                repeat (BIT_CYCLES / 2) @(negedge clk);
                if (txd !== 1'b0) begin
                    frame_err = 1'b1;
                end else begin
                    for (int i = 0; i < 8; i++) begin
                        repeat (BIT_CYCLES) @(negedge clk);
                        data[i] = txd;
                    end
                    // First stop bit
                    repeat (BIT_CYCLES) @(negedge clk);
                    rx_byte   = data;
                    rx_valid  = 1'b1;
                    frame_err = (txd !== 1'b1);
                end
            end
        end
    end

endmodule

/* tb/data_sender_tb.sv */
`timescale 1ns/1ns

module data_sender_tb;
    import sender_pkg::*;

    localparam int CLK_FREQ    = 1_000_000;
    localparam int BAUD_RATE   = 100_000;
    localparam int FIFO_DEPTH  = 64;
    localparam int RESET_WAIT  = 15;
    localparam int BIT_CYCLES  = CLK_FREQ / BAUD_RATE;
    localparam int BYTE_CYCLES = 11 * BIT_CYCLES;

    logic    clk       = 1'b0;
    logic    rst       = 1'b1;
    msg_t    msg       = '0;
    logic    msg_ready = 1'b0;
    cmd_t    cmd       = '0;
    status_t status    = '0;
    logic    txd;
    logic    ready;

    logic [7:0] rx_byte;
    logic       rx_valid;
    logic       frame_err;
    logic       startup = 1'b0;

    logic [7:0]  exp_q[$];
    logic [31:0] lfsr_state    = 32'h5ce208be;
    int          rx_count      = 0;
    int          cycle_count   = 0;
    int          budget_cycles = 300 + RESET_WAIT;
    string       hex_digits    = "0123456789ABCDEF";

    data_sender #(
        .CLK_FREQ(CLK_FREQ), .BAUD_RATE(BAUD_RATE),
        .FIFO_DEPTH(FIFO_DEPTH), .RESET_WAIT(RESET_WAIT)
    ) u_data_sender (
        .clk(clk), .rst(rst), .msg(msg), .msg_ready(msg_ready), .cmd(cmd),
        .status(status), .txd(txd), .ready(ready)
    );

    uart_decoder #(.BIT_CYCLES(BIT_CYCLES)) u_decoder (
        .clk(clk), .txd(txd), .rx_byte(rx_byte), .rx_valid(rx_valid), .frame_err(frame_err)
    );

    always #5 clk = ~clk;

    task automatic end_with_failure();
        $display("sim failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_mismatch(input string what);
        $display("MISMATCH at %0t ns: %s", $time, what);
        end_with_failure();
    endtask

    task automatic report_error(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        end_with_failure();
    endtask

    ////////////////////////////////////////
    // Random source and expected bytes
    ////////////////////////////////////////
    function automatic logic next_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = {1'b0, lfsr_state[31:1]} ^ (out ? 32'h80200003 : 32'h0);
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    function automatic msg_t random_message(input int len);
        msg_t m;
        m.length = MSG_LEN_W'(len);
        for (int i = 0; i < MSG_BYTES; i++) begin
            m.payload[i*8 +: 8] = 8'(rand_bits(8));
        end
        return m;
    endfunction

    function automatic msg_t place_escape(input msg_t m, input int pos);
        m.payload[(MSG_BYTES - 1 - pos) * 8 +: 8] = ESC_BYTE;
        return m;
    endfunction

    function automatic void allow_cycles(input int n);
        budget_cycles += n;
    endfunction

    function automatic void expect_byte(input logic [7:0] b);
        exp_q.push_back(b);
        allow_cycles(BYTE_CYCLES);
    endfunction

    // Escape byte goes out twice
    function automatic void expect_stuffed(input logic [7:0] b);
        expect_byte(b);
        if (b == ESC_BYTE) begin
            expect_byte(b);
        end
    endfunction

    function automatic void expect_message(input msg_t m);
        expect_byte(8'h21);
        expect_byte(hex_digits[m.length]);
        for (int i = 0; i < m.length; i++) begin
            expect_stuffed(m.payload[(MSG_BYTES - 1 - i) * 8 +: 8]);
        end
        expect_byte(8'h0D);
        expect_byte(8'h0A);
    endfunction

    function automatic void expect_status(input status_t s);
        for (int i = 3; i >= 0; i--) begin
            expect_stuffed(s.word[i*8 +: 8]);
        end
        expect_stuffed({5'b00000, s.capture_implemented, s.armed, s.triggered});
        expect_byte(8'h0D);
        expect_byte(8'h0A);
    endfunction

    ////////////////////////////////////////
    // Stimulus driven from the falling edge
    ////////////////////////////////////////
    task automatic send_message(input msg_t m);
        while (!ready) @(negedge clk);
        expect_message(m);
        allow_cycles(100);
        msg       = m;
        msg_ready = 1'b1;
        @(negedge clk);
        msg_ready = 1'b0;
    endtask

    task automatic issue_command(input logic [7:0] c);
        allow_cycles(100);
        cmd.valid = 1'b1;
        cmd.char  = c;
        @(negedge clk);
        cmd.valid = 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) @(negedge clk);
        // Rest of the stop bits
        repeat (2 * BIT_CYCLES) @(negedge clk);
        while (!ready) @(negedge clk);
    endtask

    task automatic run_command(input logic [7:0] c);
        expect_byte(ESC_BYTE);
        expect_byte(c);
        issue_command(c);
        wait_drained();
    endtask

    ////////////////////////////////////////
    // Checks and watchdog
    ////////////////////////////////////////
    always @(posedge clk) begin
        if (rx_valid) begin
            rx_count++;
            if (exp_q.size() == 0) begin
                report_error($sformatf("byte %02h arrived with nothing expected", rx_byte));
            end else begin
                a_byte_match: assert (rx_byte == exp_q[0])
                    else report_mismatch($sformatf("decoded %02h, expected %02h",
                                                   rx_byte, exp_q[0]));
                void'(exp_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > budget_cycles) begin
            report_error($sformatf("watchdog expired after %0d cycles", cycle_count));
        end
    end

    a_startup_quiet: assert property (@(posedge clk) startup |-> (txd && !ready))
        else report_mismatch("txd low or ready high during reset and settle wait");

    a_frame_bits: assert property (@(posedge clk) !frame_err)
        else report_error("decoder saw a broken start or stop bit");

    initial begin
        msg_t m;
        int   settle;
        int   rx_base;
        @(negedge clk);
        startup = 1'b1;
        repeat (9) @(negedge clk);
        rst    = 1'b0;
        settle = 0;
        while (!ready && settle < 100) begin
            @(negedge clk);
            settle++;
        end
        startup = 1'b0;
        // INIT for one cycle and then the settle wait
        a_settle_time: assert (settle == RESET_WAIT + 2)
            else report_mismatch($sformatf("ready rose after %0d cycles", settle));

        send_message(random_message(int'(rand_bits(4))));
        wait_drained();

        // Three escapes with two of them back to back
        m = random_message(8);
        m = place_escape(m, 0);
        m = place_escape(m, 3);
        m = place_escape(m, 4);
        send_message(m);
        wait_drained();

        run_command(CMD_C);
        run_command(CMD_W);
        issue_command(8'h58);
        allow_cycles(2 * BYTE_CYCLES);
        repeat (2 * BYTE_CYCLES) begin
            @(negedge clk);
            a_ready_kept: assert (ready)
                else report_mismatch("ready low after an ignored command");
        end

        status.word        = rand_bits(32);
        status.word[23:16] = ESC_BYTE;
        {status.capture_implemented, status.armed, status.triggered} = 3'(rand_bits(3));
        expect_byte(ESC_BYTE);
        expect_byte(CMD_R);
        expect_status(status);
        issue_command(CMD_R);
        wait_drained();

        // Flush while the fourth byte of a long frame is on the line
        m = random_message(15);
        m = place_escape(m, 5);
        m = place_escape(m, 9);
        send_message(m);
        rx_base = rx_count;
        while (rx_count < rx_base + 3) @(negedge clk);
        repeat (3 * BIT_CYCLES) @(negedge clk);
        while (exp_q.size() > 1) begin
            void'(exp_q.pop_back());
        end
        run_command(CMD_C);
        send_message(random_message(int'(rand_bits(4))));
        wait_drained();

        $display("sim passed");
        $finish;
    end

endmodule

/* build.f */
verilog/sender_pkg.sv
verilog/frame_sender_ctrl.sv
verilog/frame_shifter.sv
verilog/byte_fifo.sv
verilog/baud_timer.sv
verilog/uart_tx.sv
verilog/data_sender.sv
tb/uart_decoder.sv
tb/data_sender_tb.sv

/* Bender.yml */
package:
  name: data_sender

sources:
  - verilog/sender_pkg.sv
  - verilog/frame_sender_ctrl.sv
  - verilog/frame_shifter.sv
  - verilog/byte_fifo.sv
  - verilog/baud_timer.sv
  - verilog/uart_tx.sv
  - verilog/data_sender.sv
  - target: test
    files:
      - tb/uart_decoder.sv
      - tb/data_sender_tb.sv
